// ==== rtl/arb_config_regs.sv ====
`timescale 1ns/1ns

module arb_config_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        cfg_we,
	input  logic [1:0]                  cfg_addr,
	input  logic [mem_pkg::cnt_w-1:0]   cfg_wdata,
	output logic [mem_pkg::cnt_w-1:0]   cfg_rdata,
	input  logic                        grant_strobe,
	input  logic                        grant_user,
	output logic                        prio_m1
);

	import mem_pkg::*;

	logic             prio_q;
	logic [cnt_w-1:0] cnt0_q, cnt1_q;
	logic             wr_prio, wr_cnt0, wr_cnt1;

	assign wr_prio = cfg_we && (cfg_addr == cfg_addr_prio);
	assign wr_cnt0 = cfg_we && (cfg_addr == cfg_addr_cnt0);
	assign wr_cnt1 = cfg_we && (cfg_addr == cfg_addr_cnt1);

	always_ff @(posedge clk) begin
		if (reset) begin
			prio_q <= 1'b0;
			cnt0_q <= '0;
			cnt1_q <= '0;
		end else begin
			if (wr_prio)
				prio_q <= cfg_wdata[0]; // only bit 0 is kept.

			// a write clears the counter and wins over a same-cycle grant.
			if (wr_cnt0)
				cnt0_q <= '0;
			else if (grant_strobe && !grant_user)
				cnt0_q <= cnt0_q + 1'b1;

			if (wr_cnt1)
				cnt1_q <= '0;
			else if (grant_strobe && grant_user)
				cnt1_q <= cnt1_q + 1'b1;
		end
	end

	assign prio_m1 = prio_q;

	always_comb begin
		cfg_rdata = '0; // unmapped addresses read zero.
		case (cfg_addr)
			cfg_addr_prio: cfg_rdata = {{(cnt_w-1){1'b0}}, prio_q};
			cfg_addr_cnt0: cfg_rdata = cnt0_q;
			cfg_addr_cnt1: cfg_rdata = cnt1_q;
			default:       cfg_rdata = '0;
		endcase
	end

endmodule

// ==== rtl/bus_arbiter_mux.sv ====
`timescale 1ns/1ns

module bus_arbiter_mux (
	input  logic                          clk,
	input  logic                          reset,
	// master 0.
	input  logic                          m0_bid,
	input  logic                          m0_reqcyc,
	input  bus_pkg::bus_op_e              m0_req_op,
	input  logic [bus_pkg::addr_w-1:0]    m0_req_addr,
	input  logic [bus_pkg::data_w-1:0]    m0_req_data,
	input  logic [bus_pkg::tag_w-1:0]     m0_reqtag,
	input  logic                          m0_respack,
	output logic                          m0_reqack,
	output logic                          m0_respcyc,
	output logic [bus_pkg::data_w-1:0]    m0_resp_data,
	output logic [bus_pkg::tag_w-1:0]     m0_resptag,
	// master 1.
	input  logic                          m1_bid,
	input  logic                          m1_reqcyc,
	input  bus_pkg::bus_op_e              m1_req_op,
	input  logic [bus_pkg::addr_w-1:0]    m1_req_addr,
	input  logic [bus_pkg::data_w-1:0]    m1_req_data,
	input  logic [bus_pkg::tag_w-1:0]     m1_reqtag,
	input  logic                          m1_respack,
	output logic                          m1_reqack,
	output logic                          m1_respcyc,
	output logic [bus_pkg::data_w-1:0]    m1_resp_data,
	output logic [bus_pkg::tag_w-1:0]     m1_resptag,
	// target side.
	output logic                          bid,
	output logic                          reqcyc,
	output bus_pkg::bus_op_e              req_op,
	output logic [bus_pkg::addr_w-1:0]    req_addr,
	output logic [bus_pkg::data_w-1:0]    req_data,
	output logic [bus_pkg::tag_w-1:0]     reqtag,
	output logic                          respack,
	input  logic                          reqack,
	input  logic                          respcyc,
	input  logic [bus_pkg::data_w-1:0]    resp_data,
	input  logic [bus_pkg::tag_w-1:0]     resptag,
	// configuration block.
	input  logic                          prio_m1,
	output logic                          grant_strobe,
	output logic                          grant_user
);

	import bus_pkg::*;

	arb_state_e state_q, state_d;
	logic       owner_q, owner_d; // 0 = master 0, 1 = master 1.
	logic       owner_bid;
	logic       sel0, sel1;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= arb_idle;
			owner_q <= 1'b0;
		end else begin
			state_q <= state_d;
			owner_q <= owner_d;
		end
	end

	assign owner_bid = owner_q ? m1_bid : m0_bid;

	always_comb begin
		state_d = state_q;
		owner_d = owner_q;
		unique case (state_q)
			arb_idle: begin
				if (m0_bid && m1_bid) begin
					// tie goes to the priority bit.
					state_d = arb_busy;
					owner_d = prio_m1;
				end else if (m0_bid) begin
					state_d = arb_busy;
					owner_d = 1'b0;
				end else if (m1_bid) begin
					state_d = arb_busy;
					owner_d = 1'b1;
				end
			end
			arb_busy: begin
				if (!owner_bid)
					state_d = arb_idle; // released in the same cycle.
			end
		endcase
	end

	// routing follows the next state so a fresh bid passes straight through.
	assign sel0 = (state_d == arb_busy) && !owner_d;
	assign sel1 = (state_d == arb_busy) && owner_d;

	assign grant_strobe = (state_q == arb_idle) && (state_d == arb_busy);
	assign grant_user   = owner_d;

	always_comb begin
		bid      = 1'b0;
		reqcyc   = 1'b0;
		req_op   = op_read;
		req_addr = '0;
		req_data = '0;
		reqtag   = '0;
		respack  = 1'b0;
		if (sel0) begin
			bid      = m0_bid;
			reqcyc   = m0_reqcyc;
			req_op   = m0_req_op;
			req_addr = m0_req_addr;
			req_data = m0_req_data;
			reqtag   = m0_reqtag;
			respack  = m0_respack;
		end else if (sel1) begin
			bid      = m1_bid;
			reqcyc   = m1_reqcyc;
			req_op   = m1_req_op;
			req_addr = m1_req_addr;
			req_data = m1_req_data;
			reqtag   = m1_reqtag;
			respack  = m1_respack;
		end
	end

	// responses reach only the owner. the loser sees zeros.
	always_comb begin
		m0_reqack    = 1'b0;
		m0_respcyc   = 1'b0;
		m0_resp_data = '0;
		m0_resptag   = '0;
		if (sel0) begin
			m0_reqack    = reqack;
			m0_respcyc   = respcyc;
			m0_resp_data = resp_data;
			m0_resptag   = resptag;
		end
	end

	always_comb begin
		m1_reqack    = 1'b0;
		m1_respcyc   = 1'b0;
		m1_resp_data = '0;
		m1_resptag   = '0;
		if (sel1) begin
			m1_reqack    = reqack;
			m1_respcyc   = respcyc;
			m1_resp_data = resp_data;
			m1_resptag   = resptag;
		end
	end

endmodule

// ==== rtl/bus_memory.sv ====
`timescale 1ns/1ns

module bus_memory (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          bid,
	input  logic                          reqcyc,
	input  bus_pkg::bus_op_e              req_op,
	input  logic [bus_pkg::addr_w-1:0]    req_addr,
	input  logic [bus_pkg::data_w-1:0]    req_data,
	input  logic [bus_pkg::tag_w-1:0]     reqtag,
	input  logic                          respack,
	output logic                          reqack,
	output logic                          respcyc,
	output logic [bus_pkg::data_w-1:0]    resp_data,
	output logic [bus_pkg::tag_w-1:0]     resptag
);

	import bus_pkg::*;
	import mem_pkg::*;

	// bid is not used by the logic, requests are taken on reqcyc alone.
	// it stays on the port so bound checkers can see the owner's bid.

	localparam int dly_w = $clog2(resp_delay + 1);

	mem_state_e        state_q;
	logic              reqack_q;
	logic [dly_w-1:0]  dly_q;
	logic [data_w-1:0] resp_data_q;
	logic [tag_w-1:0]  resptag_q;
	logic              accept;

	logic [data_w-1:0] mem_q [mem_words];

	assign accept = (state_q == mem_ready) && reqcyc;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q  <= mem_ready;
			reqack_q <= 1'b0;
			dly_q    <= '0;
		end else begin
			reqack_q <= accept; // one-cycle pulse, the fsm leaves ready.
			unique case (state_q)
				mem_ready: begin
					if (reqcyc) begin
						state_q <= mem_wait;
						dly_q   <= '0;
					end
				end
				mem_wait: begin
					if (dly_q == dly_w'(resp_delay - 1))
						state_q <= mem_respond;
					else
						dly_q <= dly_q + 1'b1;
				end
				mem_respond: begin
					if (respack)
						state_q <= mem_ready; // ready the cycle after respack.
				end
				default: state_q <= mem_ready;
			endcase
		end
	end

	// array and response payload, captured at accept.
	always_ff @(posedge clk) begin
		if (accept) begin
			resp_data_q <= mem_q[req_addr]; // old word, also for a write.
			resptag_q   <= reqtag;
			if (req_op == op_write)
				mem_q[req_addr] <= req_data;
		end
	end

	assign reqack    = reqack_q;
	assign respcyc   = (state_q == mem_respond);
	assign resp_data = resp_data_q;
	assign resptag   = resptag_q;

endmodule

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

	// request and response field widths.
	localparam int addr_w = 8;
	localparam int data_w = 32;
	localparam int tag_w = 4;

	// request opcode carried with reqcyc.
	typedef enum logic {
		op_read,
		op_write
	} bus_op_e;

	// arbiter ownership state.
	typedef enum logic {
		arb_idle, // no owner, next bidder wins.
		arb_busy  // owner holds the bus while bidding.
	} arb_state_e;

endpackage

// ==== rtl/bus_subsystem_top.sv ====
`timescale 1ns/1ns

module bus_subsystem_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          m0_bid,
	input  logic                          m0_reqcyc,
	input  bus_pkg::bus_op_e              m0_req_op,
	input  logic [bus_pkg::addr_w-1:0]    m0_req_addr,
	input  logic [bus_pkg::data_w-1:0]    m0_req_data,
	input  logic [bus_pkg::tag_w-1:0]     m0_reqtag,
	input  logic                          m0_respack,
	output logic                          m0_reqack,
	output logic                          m0_respcyc,
	output logic [bus_pkg::data_w-1:0]    m0_resp_data,
	output logic [bus_pkg::tag_w-1:0]     m0_resptag,
	input  logic                          m1_bid,
	input  logic                          m1_reqcyc,
	input  bus_pkg::bus_op_e              m1_req_op,
	input  logic [bus_pkg::addr_w-1:0]    m1_req_addr,
	input  logic [bus_pkg::data_w-1:0]    m1_req_data,
	input  logic [bus_pkg::tag_w-1:0]     m1_reqtag,
	input  logic                          m1_respack,
	output logic                          m1_reqack,
	output logic                          m1_respcyc,
	output logic [bus_pkg::data_w-1:0]    m1_resp_data,
	output logic [bus_pkg::tag_w-1:0]     m1_resptag,
	input  logic                          cfg_we,
	input  logic [1:0]                    cfg_addr,
	input  logic [mem_pkg::cnt_w-1:0]     cfg_wdata,
	output logic [mem_pkg::cnt_w-1:0]     cfg_rdata
);

	import bus_pkg::*;

	// shared target bus.
	logic              bid, reqcyc, respack;
	bus_op_e           req_op;
	logic [addr_w-1:0] req_addr;
	logic [data_w-1:0] req_data;
	logic [tag_w-1:0]  reqtag;
	logic              reqack, respcyc;
	logic [data_w-1:0] resp_data;
	logic [tag_w-1:0]  resptag;

	logic prio_m1, grant_strobe, grant_user; // arbiter to config regs.

	bus_arbiter_mux u_bus_arbiter_mux (
		.clk          (clk),
		.reset        (reset),
		.m0_bid       (m0_bid),
		.m0_reqcyc    (m0_reqcyc),
		.m0_req_op    (m0_req_op),
		.m0_req_addr  (m0_req_addr),
		.m0_req_data  (m0_req_data),
		.m0_reqtag    (m0_reqtag),
		.m0_respack   (m0_respack),
		.m0_reqack    (m0_reqack),
		.m0_respcyc   (m0_respcyc),
		.m0_resp_data (m0_resp_data),
		.m0_resptag   (m0_resptag),
		.m1_bid       (m1_bid),
		.m1_reqcyc    (m1_reqcyc),
		.m1_req_op    (m1_req_op),
		.m1_req_addr  (m1_req_addr),
		.m1_req_data  (m1_req_data),
		.m1_reqtag    (m1_reqtag),
		.m1_respack   (m1_respack),
		.m1_reqack    (m1_reqack),
		.m1_respcyc   (m1_respcyc),
		.m1_resp_data (m1_resp_data),
		.m1_resptag   (m1_resptag),
		.bid          (bid),
		.reqcyc       (reqcyc),
		.req_op       (req_op),
		.req_addr     (req_addr),
		.req_data     (req_data),
		.reqtag       (reqtag),
		.respack      (respack),
		.reqack       (reqack),
		.respcyc      (respcyc),
		.resp_data    (resp_data),
		.resptag      (resptag),
		.prio_m1      (prio_m1),
		.grant_strobe (grant_strobe),
		.grant_user   (grant_user)
	);

	arb_config_regs u_arb_config_regs (
		.clk          (clk),
		.reset        (reset),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.grant_strobe (grant_strobe),
		.grant_user   (grant_user),
		.prio_m1      (prio_m1)
	);

	bus_memory u_bus_memory (
		.clk       (clk),
		.reset     (reset),
		.bid       (bid),
		.reqcyc    (reqcyc),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_data  (req_data),
		.reqtag    (reqtag),
		.respack   (respack),
		.reqack    (reqack),
		.respcyc   (respcyc),
		.resp_data (resp_data),
		.resptag   (resptag)
	);

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

	// memory target geometry and timing.
	localparam int mem_words = 256;
	localparam int resp_delay = 2; // reqack to respcyc, in cycles.

	// configuration register map.
	localparam logic [1:0] cfg_addr_prio = 2'd0;
	localparam logic [1:0] cfg_addr_cnt0 = 2'd1;
	localparam logic [1:0] cfg_addr_cnt1 = 2'd2;

	localparam int cnt_w = 16; // grant counters wrap at this width.

	typedef enum logic [1:0] {
		mem_ready,   // waiting for reqcyc.
		mem_wait,    // counting down the response delay.
		mem_respond  // holding respcyc until respack.
	} mem_state_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bus subsystem testbench with verilator.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module bus_subsystem_tb --Mdir obj_dir -o bus_subsystem_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see $build_log"
	exit 1
fi

./obj_dir/bus_subsystem_sim > "$sim_log" 2>&1
sim_status=$?

if grep -q "SOME TESTS FAILED" "$sim_log"; then
	echo "simulation reported failures, see $sim_log"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see $sim_log"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== tb/bus_subsystem_checker.sv ====
`timescale 1ns/1ns

module bus_subsystem_checker (
	input logic                 clk,
	input logic                 reset,
	input logic                 m0_reqack,
	input logic                 m0_respcyc,
	input logic                 m1_reqack,
	input logic                 m1_respcyc,
	input logic                 reqack,
	input logic                 grant_strobe,
	input logic                 bid
);

	// the target talks to one master at a time.
	a_single_owner: assert property (@(posedge clk) disable iff (reset)
		!((m0_reqack || m0_respcyc) && (m1_reqack || m1_respcyc)))
		else $error("reqack or respcyc reached both masters in one cycle");

	a_reqack_pulse: assert property (@(posedge clk) disable iff (reset)
		reqack |=> !reqack)
		else $error("reqack stayed high for two cycles");

	// a grant only starts after a cycle with no owner bid on the target.
	a_grant_from_idle: assert property (@(posedge clk) disable iff (reset)
		grant_strobe |-> !$past(bid))
		else $error("grant_strobe while the bus still had an owner");

endmodule

bind bus_arbiter_mux bus_subsystem_checker u_bus_subsystem_checker (
	.clk          (clk),
	.reset        (reset),
	.m0_reqack    (m0_reqack),
	.m0_respcyc   (m0_respcyc),
	.m1_reqack    (m1_reqack),
	.m1_respcyc   (m1_respcyc),
	.reqack       (reqack),
	.grant_strobe (grant_strobe),
	.bid          (bid)
);

// ==== tb/bus_subsystem_tb.sv ====
`timescale 1ns/1ns

module bus_subsystem_tb;

	import bus_pkg::*;
	import mem_pkg::*;

	localparam int rounds = 4; // priority alternates per round.
	localparam int bids_per_round = 6;
	localparam int max_reqs = 3;
	localparam int planned_txn = rounds * 2 * bids_per_round * max_reqs;
	localparam int timeout_ns = (planned_txn * 40 + 60) * 4;

	logic              clk, reset;
	logic [1:0]        bid, reqcyc, respack, reqack, respcyc;
	bus_op_e           req_op [2];
	logic [addr_w-1:0] req_addr [2];
	logic [data_w-1:0] req_data [2];
	logic [tag_w-1:0]  reqtag [2];
	logic [data_w-1:0] resp_data [2];
	logic [tag_w-1:0]  resptag [2];
	logic              cfg_we;
	logic [1:0]        cfg_addr;
	logic [cnt_w-1:0]  cfg_wdata, cfg_rdata;

	logic [data_w-1:0] ref_mem [16]; // only 16 words are used.
	logic              ref_valid [16];
	logic              model_busy, model_owner, model_prio;
	logic [cnt_w-1:0]  grant_cnt [2];
	logic              tie_seen [2];
	int                cyc;
	int                req_start [2];
	logic [31:0]       rng_state [2]; // one generator per agent.

	bus_subsystem_top u_bus_subsystem_top (
		.clk (clk), .reset (reset),
		.m0_bid (bid[0]), .m0_reqcyc (reqcyc[0]), .m0_req_op (req_op[0]),
		.m0_req_addr (req_addr[0]), .m0_req_data (req_data[0]), .m0_reqtag (reqtag[0]),
		.m0_respack (respack[0]), .m0_reqack (reqack[0]), .m0_respcyc (respcyc[0]),
		.m0_resp_data (resp_data[0]), .m0_resptag (resptag[0]),
		.m1_bid (bid[1]), .m1_reqcyc (reqcyc[1]), .m1_req_op (req_op[1]),
		.m1_req_addr (req_addr[1]), .m1_req_data (req_data[1]), .m1_reqtag (reqtag[1]),
		.m1_respack (respack[1]), .m1_reqack (reqack[1]), .m1_respcyc (respcyc[1]),
		.m1_resp_data (resp_data[1]), .m1_resptag (resptag[1]),
		.cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand(input int k);
		rng_state[k] = rng_state[k] ^ (rng_state[k] << 13);
		rng_state[k] = rng_state[k] ^ (rng_state[k] >> 17);
		rng_state[k] = rng_state[k] ^ (rng_state[k] << 5);
		return rng_state[k];
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input logic [data_w-1:0] exp,
			input logic [data_w-1:0] act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic check_count(input string name, input logic [cnt_w-1:0] exp,
			input logic [cnt_w-1:0] act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
				$time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	// arbitration, isolation and latency model, sampled mid-cycle.
	task automatic step_model();
		logic busy_d, owner_d, owned;
		busy_d = model_busy;
		owner_d = model_owner;
		if (!model_busy) begin
			if (bid[0] && bid[1]) begin
				busy_d = 1'b1;
				owner_d = model_prio; // tie goes to the priority bit.
				tie_seen[model_prio] = 1'b1;
			end else if (bid[0] || bid[1]) begin
				busy_d = 1'b1;
				owner_d = bid[1];
			end
			if (busy_d)
				grant_cnt[owner_d] = grant_cnt[owner_d] + cnt_w'(1);
		end else if (!bid[model_owner]) begin
			busy_d = 1'b0; // released in the same cycle.
		end
		for (int k = 0; k < 2; k++) begin
			owned = busy_d && (owner_d == k[0]);
			if (!owned) begin
				check_bit($sformatf("m%0d_reqack", k), 1'b0, reqack[k]);
				check_bit($sformatf("m%0d_respcyc", k), 1'b0, respcyc[k]);
				check_data($sformatf("m%0d_resp_data", k), '0, resp_data[k]);
				check_data($sformatf("m%0d_resptag", k), '0, data_w'(resptag[k]));
			end else if (reqcyc[k] && req_start[k] < 0) begin
				req_start[k] = cyc;
			end
			if (req_start[k] >= 0) begin
				if (cyc == req_start[k] + 1)
					check_bit($sformatf("m%0d_reqack", k), 1'b1, reqack[k]);
				if (cyc == req_start[k] + 2) begin
					check_bit($sformatf("m%0d_reqack", k), 1'b0, reqack[k]);
					check_bit($sformatf("m%0d_respcyc", k), 1'b0, respcyc[k]);
				end
				if (cyc >= req_start[k] + 3)
					check_bit($sformatf("m%0d_respcyc", k), 1'b1, respcyc[k]);
				if (respcyc[k] && respack[k])
					req_start[k] = -1;
			end
		end
		model_busy = busy_d;
		model_owner = owner_d;
	endtask

	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!reset)
			step_model();
	end

	// one master, a series of bids with one or more requests each.
	task automatic run_agent(input int k);
		int gap, nreq, dly;
		logic [31:0] r;
		bus_op_e op;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata, exp_data;
		logic [tag_w-1:0] tag;
		logic known;
		for (int b = 0; b < bids_per_round; b++) begin
			gap = (b == 0) ? 0 : int'(next_rand(k) % 6); // first bids collide.
			nreq = 1 + int'(next_rand(k) % max_reqs);
			repeat (gap) @(posedge clk);
			@(posedge clk);
			bid[k] <= 1'b1;
			for (int i = 0; i < nreq; i++) begin
				r = next_rand(k);
				op = bus_op_e'(r[0]);
				addr = addr_w'(r[7:4]);
				wdata = next_rand(k);
				tag = r[11:8];
				req_op[k] <= op;
				req_addr[k] <= addr;
				req_data[k] <= wdata;
				reqtag[k] <= tag;
				reqcyc[k] <= 1'b1;
				@(negedge clk);
				while (reqack[k] !== 1'b1)
					@(negedge clk);
				exp_data = ref_mem[addr[3:0]];
				known = ref_valid[addr[3:0]];
				if (op == op_write) begin
					ref_mem[addr[3:0]] = wdata;
					ref_valid[addr[3:0]] = 1'b1;
				end
				@(posedge clk);
				reqcyc[k] <= 1'b0;
				@(negedge clk);
				while (respcyc[k] !== 1'b1)
					@(negedge clk);
				if (known) // unwritten words hold no defined value.
					check_data($sformatf("m%0d_resp_data", k), exp_data, resp_data[k]);
				check_data($sformatf("m%0d_resptag", k), data_w'(tag), data_w'(resptag[k]));
				dly = int'(next_rand(k) % 4);
				repeat (dly) @(posedge clk);
				@(posedge clk);
				respack[k] <= 1'b1;
				@(posedge clk);
				respack[k] <= 1'b0;
			end
			bid[k] <= 1'b0;
		end
	endtask

	task automatic write_cfg(input logic [1:0] addr, input logic [cnt_w-1:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic read_check(input string name, input logic [1:0] addr,
			input logic [cnt_w-1:0] exp);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		check_count(name, exp, cfg_rdata);
	endtask

	initial begin
		#(timeout_ns);
		abort_run("timeout: the bus transactions did not complete in the expected time");
	end

	initial begin
		reset = 1'b1;
		bid = '0;
		reqcyc = '0;
		respack = '0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		for (int k = 0; k < 2; k++) begin
			req_op[k] = op_read;
			req_addr[k] = '0;
			req_data[k] = '0;
			reqtag[k] = '0;
			grant_cnt[k] = '0;
			tie_seen[k] = 1'b0;
			req_start[k] = -1;
		end
		for (int i = 0; i < 16; i++) begin
			ref_mem[i] = '0;
			ref_valid[i] = 1'b0;
		end
		model_busy = 1'b0;
		model_owner = 1'b0;
		model_prio = 1'b0;
		cyc = 0;
		rng_state[0] = 32'h38aab1fe;
		rng_state[1] = {rng_state[0][15:0], rng_state[0][31:16]}; // seed with halves swapped.
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (int rnd = 0; rnd < rounds; rnd++) begin
			write_cfg(cfg_addr_prio, cnt_w'(rnd % 2));
			model_prio = rnd[0];
			fork
				run_agent(0);
				run_agent(1);
			join
		end
		repeat (4) @(posedge clk);
		read_check("cfg_rdata prio", cfg_addr_prio, cnt_w'(model_prio));
		read_check("cfg_rdata cnt0", cfg_addr_cnt0, grant_cnt[0]);
		read_check("cfg_rdata cnt1", cfg_addr_cnt1, grant_cnt[1]);
		write_cfg(cfg_addr_cnt0, '1);
		read_check("cfg_rdata cnt0 cleared", cfg_addr_cnt0, '0);
		write_cfg(cfg_addr_cnt1, '1);
		read_check("cfg_rdata cnt1 cleared", cfg_addr_cnt1, '0);
		check_bit("tie seen with prio 0", 1'b1, tie_seen[0]);
		check_bit("tie seen with prio 1", 1'b1, tie_seen[1]);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/bus_pkg.sv
rtl/mem_pkg.sv
rtl/bus_arbiter_mux.sv
rtl/arb_config_regs.sv
rtl/bus_memory.sv
rtl/bus_subsystem_top.sv
tb/bus_subsystem_checker.sv
tb/bus_subsystem_tb.sv
